//--- logic/crc32_byte_step.sv
// crc-32 byte step: advances the reflected ethernet crc by one data byte
`timescale 1ns/1ns
`default_nettype none

module crc32_byte_step (
    input  wire xgmii_rx_pkg::crc_t state_in,
    input  wire logic [7:0]         data_in,
    output xgmii_rx_pkg::crc_t      state_out
);

    xgmii_rx_pkg::crc_t crc;

    always_comb begin
        crc = state_in ^ {24'h000000, data_in};
        // lsb first, one shift per data bit
        for (int b = 0; b < 8; b++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ xgmii_rx_pkg::ETH_CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        state_out = crc;
    end

endmodule

`default_nettype wire

//--- logic/fcs_checker.sv
// fcs checker: running crc over each aligned word with residue flags per byte count
`timescale 1ns/1ns
`default_nettype none

module fcs_checker (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire logic                      crc_restart,
    input  wire xgmii_rx_pkg::xgmii_data_t rxd_d0,
    output logic [8:0]                     crc_ok,
    output logic [8:0]                     crc_ok_saved
);

    xgmii_rx_pkg::crc_t crc_state;

    // tap k holds the crc after the first k bytes of the word
    wire xgmii_rx_pkg::crc_t crc_tap [0:xgmii_rx_pkg::LANES];

    assign crc_tap[0] = crc_state;

    for (genvar k = 0; k < xgmii_rx_pkg::LANES; k++) begin : g_step
        crc32_byte_step u_step (
            .state_in  (crc_tap[k]),
            .data_in   (rxd_d0[k*8 +: 8]),
            .state_out (crc_tap[k+1])
        );
    end

    for (genvar k = 0; k <= xgmii_rx_pkg::LANES; k++) begin : g_ok
        assign crc_ok[k] = (crc_tap[k] == xgmii_rx_pkg::ETH_CRC_RESIDUE);
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_restart) begin
            crc_state <= '1;
        end else begin
            crc_state <= crc_tap[xgmii_rx_pkg::LANES];
        end

        // kept for a terminate in the upper lanes
        crc_ok_saved <= crc_ok;
    end

endmodule

`default_nettype wire

//--- logic/rx_frame_fsm.sv
// frame fsm: drives the output word stream, counts length and limit, closes frames
`timescale 1ns/1ns
`default_nettype none

module rx_frame_fsm #(
    parameter int max_frame_len = 1518
) (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire logic                      rx_enable,
    input  wire xgmii_rx_pkg::xgmii_data_t rxd_d1,
    input  wire logic                      start_d1,
    input  wire logic                      term_present,
    input  wire xgmii_rx_pkg::lane_idx_t   term_lane,
    input  wire logic                      framing_error,
    input  wire logic                      framing_error_d0,
    input  wire logic                      term_present_d0,
    input  wire xgmii_rx_pkg::lane_idx_t   term_lane_d0,
    input  wire logic [8:0]                crc_ok,
    input  wire logic [8:0]                crc_ok_saved,
    output logic                           crc_restart,
    output xgmii_rx_pkg::xgmii_data_t      m_tdata,
    output xgmii_rx_pkg::xgmii_ctrl_t      m_tkeep,
    output logic                           m_tvalid,
    output logic                           m_tlast,
    output logic                           m_tuser,
    output xgmii_rx_pkg::frame_len_t       stat_pkt_len,
    output logic                           stat_pkt_good,
    output logic                           stat_pkt_bad,
    output logic                           stat_err_bad_fcs,
    output logic                           stat_err_framing,
    output logic                           stat_err_oversize
);

    typedef enum logic [1:0] {
        state_idle,
        state_payload,
        state_last
    } state_t;

    state_t state, state_next;
    xgmii_rx_pkg::frame_len_t len_cnt, len_next;
    xgmii_rx_pkg::frame_len_t lim_cnt, lim_next;
    xgmii_rx_pkg::frame_len_t close_len;
    xgmii_rx_pkg::xgmii_ctrl_t tkeep_next;
    logic oversize, oversize_next;
    logic tvalid_next;
    logic close_frame, close_fcs_ok, close_framing, close_oversize, close_good;

    always_comb begin
        state_next = state;
        crc_restart = 1'b0;
        oversize_next = oversize;
        tkeep_next = '1;
        tvalid_next = 1'b0;
        close_frame = 1'b0;
        close_fcs_ok = 1'b1;
        close_framing = 1'b0;
        close_oversize = 1'b0;
        close_len = len_cnt;

        // bytes through rxd_d0, fcs included
        if (&len_cnt[15:3]) begin
            len_next = '1;
        end else if (term_present) begin
            len_next = len_cnt + xgmii_rx_pkg::frame_len_t'(term_lane);
        end else begin
            len_next = len_cnt + xgmii_rx_pkg::frame_len_t'(xgmii_rx_pkg::LANES);
        end

        // remaining budget, floors at zero
        if (lim_cnt[15:3] != '0) begin
            lim_next = lim_cnt - xgmii_rx_pkg::frame_len_t'(xgmii_rx_pkg::LANES);
        end else begin
            lim_next = '0;
        end

        case (state)
            state_idle: begin
                crc_restart = 1'b1;
                len_next = xgmii_rx_pkg::frame_len_t'(xgmii_rx_pkg::LANES);
                lim_next = xgmii_rx_pkg::frame_len_t'(max_frame_len);
                // rxd_d1 holds the preamble word here
                if (start_d1 && rx_enable) begin
                    crc_restart = 1'b0;
                    state_next = state_payload;
                end
            end
            state_payload: begin
                tvalid_next = 1'b1;
                if (term_present) begin
                    oversize_next = lim_cnt < xgmii_rx_pkg::frame_len_t'(8 + term_lane);
                end else begin
                    oversize_next = lim_cnt < xgmii_rx_pkg::frame_len_t'(8);
                end

                if (framing_error || framing_error_d0) begin
                    close_frame = 1'b1;
                    close_framing = 1'b1;
                    close_oversize = oversize_next;
                    close_len = len_next;
                    crc_restart = 1'b1;
                    state_next = state_idle;
                end else if (term_present) begin
                    crc_restart = 1'b1;
                    if (term_lane <= 3'd4) begin
                        // fcs ends inside this word
                        tkeep_next = 8'hff >> (3'd4 - term_lane);
                        close_frame = 1'b1;
                        close_fcs_ok = crc_ok[term_lane];
                        close_oversize = oversize_next;
                        close_len = len_next;
                        state_next = state_idle;
                    end else begin
                        state_next = state_last;
                    end
                end
            end
            state_last: begin
                // a start word right behind is picked up from idle
                tvalid_next = 1'b1;
                tkeep_next = 8'hff >> (4'd12 - {1'b0, term_lane_d0});
                crc_restart = 1'b1;
                close_frame = 1'b1;
                close_fcs_ok = term_present_d0 && crc_ok_saved[term_lane_d0];
                close_oversize = oversize;
                state_next = state_idle;
            end
            default: begin
                state_next = state_idle;
            end
        endcase

        close_good = close_fcs_ok && !close_framing && !close_oversize;
    end

    always_ff @(posedge clk) begin
        state <= state_next;
        len_cnt <= len_next;
        lim_cnt <= lim_next;
        oversize <= oversize_next;

        m_tdata <= rxd_d1;
        m_tkeep <= tkeep_next;
        m_tvalid <= tvalid_next;
        m_tlast <= close_frame;
        m_tuser <= close_frame && !close_good;

        stat_pkt_len <= close_frame ? close_len : '0;
        stat_pkt_good <= close_frame && close_good;
        stat_pkt_bad <= close_frame && !close_good;
        stat_err_bad_fcs <= close_frame && !close_fcs_ok;
        stat_err_framing <= close_frame && close_framing;
        stat_err_oversize <= close_frame && close_oversize;

        if (reset_crc) begin
            state <= state_idle;
            m_tvalid <= 1'b0;
            m_tlast <= 1'b0;
            m_tuser <= 1'b0;
            stat_pkt_len <= '0;
            stat_pkt_good <= 1'b0;
            stat_pkt_bad <= 1'b0;
            stat_err_bad_fcs <= 1'b0;
            stat_err_framing <= 1'b0;
            stat_err_oversize <= 1'b0;
        end
    end

    a_last_valid: assert property (@(posedge clk) disable iff (reset_crc)
        m_tlast |-> m_tvalid);

    // the preamble slot leaves one empty output cycle between frames
    a_gap_after_last: assert property (@(posedge clk) disable iff (reset_crc)
        m_tlast |=> !m_tvalid);

endmodule

`default_nettype wire

//--- logic/xgmii_lane_align.sv
// xgmii lane aligner: masks control bytes, finds start and terminate, flags stray controls
`timescale 1ns/1ns
`default_nettype none

module xgmii_lane_align (
    input  wire logic                     clk,
    input  wire logic                     reset_crc,
    input  wire xgmii_rx_pkg::xgmii_data_t xgmii_rxd,
    input  wire xgmii_rx_pkg::xgmii_ctrl_t xgmii_rxc,
    output xgmii_rx_pkg::xgmii_data_t     rxd_d0,
    output xgmii_rx_pkg::xgmii_data_t     rxd_d1,
    output logic                          start_d0,
    output logic                          start_d1,
    output logic                          term_present,
    output xgmii_rx_pkg::lane_idx_t       term_lane,
    output logic                          framing_error,
    output logic                          framing_error_d0,
    output logic                          term_present_d0,
    output xgmii_rx_pkg::lane_idx_t       term_lane_d0
);

    xgmii_rx_pkg::xgmii_data_t rxd_masked;
    xgmii_rx_pkg::xgmii_ctrl_t term_hit;
    xgmii_rx_pkg::xgmii_ctrl_t below_term;
    xgmii_rx_pkg::lane_idx_t term_idx;
    logic term_found;
    logic start_hit;
    logic ctrl_err;

    always_comb begin
        for (int i = 0; i < xgmii_rx_pkg::LANES; i++) begin
            rxd_masked[i*8 +: 8] = xgmii_rxc[i] ? 8'h00 : xgmii_rxd[i*8 +: 8];
            term_hit[i] = xgmii_rxc[i] && (xgmii_rxd[i*8 +: 8] == xgmii_rx_pkg::XGMII_TERM);
        end

        // lowest terminate lane wins
        term_found = 1'b0;
        term_idx = '0;
        for (int i = xgmii_rx_pkg::LANES - 1; i >= 0; i--) begin
            if (term_hit[i]) begin
                term_found = 1'b1;
                term_idx = xgmii_rx_pkg::lane_idx_t'(i);
            end
        end

        start_hit = xgmii_rxc[0] && (xgmii_rxd[7:0] == xgmii_rx_pkg::XGMII_START);
        below_term = (8'd1 << term_idx) - 8'd1;

        // any control where only data may appear
        if (start_hit) begin
            ctrl_err = |xgmii_rxc[7:1];
        end else if (term_found) begin
            ctrl_err = |(xgmii_rxc & below_term);
        end else begin
            ctrl_err = |xgmii_rxc;
        end
    end

    always_ff @(posedge clk) begin
        rxd_d0 <= rxd_masked;
        start_d0 <= start_hit;
        term_present <= term_found;
        term_lane <= term_idx;
        framing_error <= ctrl_err;

        // second stage, one word behind
        rxd_d1 <= rxd_d0;
        start_d1 <= start_d0;
        term_present_d0 <= term_present;
        term_lane_d0 <= term_lane;
        framing_error_d0 <= framing_error;

        if (reset_crc) begin
            start_d0 <= 1'b0;
            start_d1 <= 1'b0;
            term_present <= 1'b0;
            term_present_d0 <= 1'b0;
            framing_error <= 1'b0;
            framing_error_d0 <= 1'b0;
        end
    end

    // start and terminate never share a word
    a_start_not_term: assert property (@(posedge clk) disable iff (reset_crc)
        start_d0 |-> !term_present);

endmodule

`default_nettype wire

//--- logic/xgmii_rx_pkg.sv
// xgmii receive path: character codes, crc constants and shared word types
`default_nettype none

package xgmii_rx_pkg;

    localparam int LANES = 8;

    typedef logic [63:0] xgmii_data_t;
    typedef logic [LANES-1:0] xgmii_ctrl_t;
    typedef logic [2:0] lane_idx_t;
    // frame length in bytes, sticks at all ones
    typedef logic [15:0] frame_len_t;
    typedef logic [31:0] crc_t;

    // xgmii control characters
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // reflected ethernet polynomial
    localparam crc_t ETH_CRC_POLY = 32'hedb88320;
    // register value after data plus a good fcs, init all ones, no final xor
    localparam crc_t ETH_CRC_RESIDUE = 32'hdebb20e3;

endpackage

`default_nettype wire

//--- logic/xgmii_rx_top.sv
// xgmii frame receiver top: lane aligner, fcs checker and frame fsm
`timescale 1ns/1ns
`default_nettype none

module xgmii_rx_top #(
    parameter int max_frame_len = 1518
) (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire logic                      rx_enable,
    input  wire xgmii_rx_pkg::xgmii_data_t xgmii_rxd,
    input  wire xgmii_rx_pkg::xgmii_ctrl_t xgmii_rxc,
    output xgmii_rx_pkg::xgmii_data_t      m_tdata,
    output xgmii_rx_pkg::xgmii_ctrl_t      m_tkeep,
    output logic                           m_tvalid,
    output logic                           m_tlast,
    output logic                           m_tuser,
    output xgmii_rx_pkg::frame_len_t       stat_pkt_len,
    output logic                           stat_pkt_good,
    output logic                           stat_pkt_bad,
    output logic                           stat_err_bad_fcs,
    output logic                           stat_err_framing,
    output logic                           stat_err_oversize
);

    xgmii_rx_pkg::xgmii_data_t rxd_d0, rxd_d1;
    xgmii_rx_pkg::lane_idx_t term_lane, term_lane_d0;
    logic start_d1;
    logic term_present, term_present_d0;
    logic framing_error, framing_error_d0;
    logic crc_restart;
    logic [8:0] crc_ok, crc_ok_saved;

    xgmii_lane_align u_align (
        .clk              (clk),
        .reset_crc        (reset_crc),
        .xgmii_rxd        (xgmii_rxd),
        .xgmii_rxc        (xgmii_rxc),
        .rxd_d0           (rxd_d0),
        .rxd_d1           (rxd_d1),
        .start_d0         (),
        .start_d1         (start_d1),
        .term_present     (term_present),
        .term_lane        (term_lane),
        .framing_error    (framing_error),
        .framing_error_d0 (framing_error_d0),
        .term_present_d0  (term_present_d0),
        .term_lane_d0     (term_lane_d0)
    );

    fcs_checker u_fcs (
        .clk          (clk),
        .reset_crc    (reset_crc),
        .crc_restart  (crc_restart),
        .rxd_d0       (rxd_d0),
        .crc_ok       (crc_ok),
        .crc_ok_saved (crc_ok_saved)
    );

    rx_frame_fsm #(
        .max_frame_len (max_frame_len)
    ) u_fsm (
        .clk               (clk),
        .reset_crc         (reset_crc),
        .rx_enable         (rx_enable),
        .rxd_d1            (rxd_d1),
        .start_d1          (start_d1),
        .term_present      (term_present),
        .term_lane         (term_lane),
        .framing_error     (framing_error),
        .framing_error_d0  (framing_error_d0),
        .term_present_d0   (term_present_d0),
        .term_lane_d0      (term_lane_d0),
        .crc_ok            (crc_ok),
        .crc_ok_saved      (crc_ok_saved),
        .crc_restart       (crc_restart),
        .m_tdata           (m_tdata),
        .m_tkeep           (m_tkeep),
        .m_tvalid          (m_tvalid),
        .m_tlast           (m_tlast),
        .m_tuser           (m_tuser),
        .stat_pkt_len      (stat_pkt_len),
        .stat_pkt_good     (stat_pkt_good),
        .stat_pkt_bad      (stat_pkt_bad),
        .stat_err_bad_fcs  (stat_err_bad_fcs),
        .stat_err_framing  (stat_err_framing),
        .stat_err_oversize (stat_err_oversize)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv --top-module xgmii_rx_tb \
    -f xgmii_rx.f -Mdir obj_dir -o xgmii_rx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/xgmii_rx_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- verification/xgmii_rx_tb.sv
// xgmii receiver testbench: random frames through the dut, stream and status checked per word
`timescale 1ns/1ns
`default_nettype none

module xgmii_rx_tb;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_LEN = 256;
    localparam int GAP = 3;
    localparam int DISABLED_GAP = 10;
    // total lengths, payload plus fcs
    localparam int BAD_FCS_LEN = 70;
    localparam int OVERSIZE_LEN = 300;
    localparam int FRAMING_LEN = 100;
    localparam int DISABLED_LEN = 64;
    localparam int B2B_FIRST_LEN = 69;
    localparam int B2B_SECOND_LEN = 78;
    localparam xgmii_rx_pkg::xgmii_data_t IDLE_DATA = {8{8'h07}};

    typedef logic [7:0] byte_q_t[$];
    typedef struct {
        xgmii_rx_pkg::frame_len_t len;
        logic bad_fcs;
        logic oversize;
        logic framing;
        int words;
    } frame_exp_t;

    logic clk;
    logic reset_crc;
    logic rx_enable;
    xgmii_rx_pkg::xgmii_data_t xgmii_rxd, m_tdata;
    xgmii_rx_pkg::xgmii_ctrl_t xgmii_rxc, m_tkeep;
    logic m_tvalid, m_tlast, m_tuser;
    xgmii_rx_pkg::frame_len_t stat_pkt_len;
    logic stat_pkt_good, stat_pkt_bad;
    logic stat_err_bad_fcs, stat_err_framing, stat_err_oversize;

    // expected words in output order, one record per frame
    xgmii_rx_pkg::xgmii_data_t exp_data_q[$];
    xgmii_rx_pkg::xgmii_ctrl_t exp_keep_q[$];
    frame_exp_t frame_q[$];

    xgmii_rx_top #(.max_frame_len(MAX_LEN)) uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input string name, input xgmii_rx_pkg::xgmii_data_t got,
                              input xgmii_rx_pkg::xgmii_data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_keep(input string name, input xgmii_rx_pkg::xgmii_ctrl_t got,
                              input xgmii_rx_pkg::xgmii_ctrl_t exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input xgmii_rx_pkg::frame_len_t got,
                             input xgmii_rx_pkg::frame_len_t exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ethernet fcs, bitwise and lsb first, sent low byte first
    function automatic xgmii_rx_pkg::crc_t fcs_of(input byte_q_t bytes);
        xgmii_rx_pkg::crc_t crc;
        logic fb;
        crc = '1;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = crc[0] ^ bytes[i][b];
                crc = {1'b0, crc[31:1]};
                if (fb) begin
                    crc = crc ^ xgmii_rx_pkg::ETH_CRC_POLY;
                end
            end
        end
        return ~crc;
    endfunction

    // fcs stripped on output, payload packed from lane 0
    function automatic void expect_frame(input byte_q_t payload, input logic corrupt,
                                         input logic framing);
        frame_exp_t rec;
        xgmii_rx_pkg::xgmii_data_t word;
        xgmii_rx_pkg::xgmii_ctrl_t keep;
        int p;
        p = payload.size();
        rec.len = xgmii_rx_pkg::frame_len_t'(p + 4);
        rec.bad_fcs = corrupt;
        rec.oversize = (p + 4) > MAX_LEN;
        rec.framing = framing;
        rec.words = (p + 7) / 8;
        frame_q.push_back(rec);
        if (!framing) begin
            for (int w = 0; w < rec.words; w++) begin
                word = '0;
                keep = '0;
                for (int i = 0; i < xgmii_rx_pkg::LANES; i++) begin
                    if (w * 8 + i < p) begin
                        word[i*8 +: 8] = payload[w*8 + i];
                        keep[i] = 1'b1;
                    end
                end
                exp_data_q.push_back(word);
                exp_keep_q.push_back(keep);
            end
        end
    endfunction

    function automatic byte_q_t random_payload(input int len);
        byte_q_t q;
        for (int i = 0; i < len; i++) begin
            q.push_back(8'($urandom()));
        end
        return q;
    endfunction

    // start word, data words up to the terminate, idle gap
    function automatic int words_sent(input int total, input int gap);
        return 1 + total / 8 + 1 + gap;
    endfunction

    task automatic drive_word(input xgmii_rx_pkg::xgmii_data_t d,
                              input xgmii_rx_pkg::xgmii_ctrl_t c);
        @(negedge clk);
        xgmii_rxd = d;
        xgmii_rxc = c;
    endtask

    // err_word below zero sends a clean frame
    task automatic send_frame(input byte_q_t payload, input logic corrupt, input int err_word,
                              input logic received, input int gap);
        byte_q_t stream;
        xgmii_rx_pkg::crc_t fcs;
        xgmii_rx_pkg::xgmii_data_t d;
        xgmii_rx_pkg::xgmii_ctrl_t c;
        int total;
        stream = payload;
        fcs = fcs_of(payload);
        for (int i = 0; i < 4; i++) begin
            stream.push_back(fcs[i*8 +: 8]);
        end
        if (corrupt) begin
            stream[payload.size() + 1] = ~stream[payload.size() + 1];
        end
        if (received) begin
            expect_frame(payload, corrupt, err_word >= 0);
        end
        total = stream.size();
        // start, six preamble bytes, sfd
        drive_word({8'hd5, {6{8'h55}}, xgmii_rx_pkg::XGMII_START}, 8'h01);
        for (int w = 0; w <= total / 8; w++) begin
            for (int i = 0; i < xgmii_rx_pkg::LANES; i++) begin
                if (w * 8 + i < total) begin
                    d[i*8 +: 8] = stream[w*8 + i];
                    c[i] = 1'b0;
                end else if (w * 8 + i == total) begin
                    d[i*8 +: 8] = xgmii_rx_pkg::XGMII_TERM;
                    c[i] = 1'b1;
                end else begin
                    d[i*8 +: 8] = 8'h07;
                    c[i] = 1'b1;
                end
            end
            if (w == err_word) begin
                d[31:24] = xgmii_rx_pkg::XGMII_ERROR;
                c[3] = 1'b1;
            end
            drive_word(d, c);
        end
        repeat (gap) drive_word(IDLE_DATA, 8'hff);
    endtask

    task automatic wait_drained();
        while (frame_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin : monitor
        int words_in_frame;
        frame_exp_t cur;
        xgmii_rx_pkg::xgmii_data_t mask;
        xgmii_rx_pkg::xgmii_ctrl_t keep;
        logic bad;
        words_in_frame = 0;
        wait (reset_crc === 1'b0);
        forever begin
            @(negedge clk);
            // status pulses only with the last word
            if (!m_tlast) begin
                check_flag("m_tuser", m_tuser, 1'b0);
                check_flag("stat_pkt_good", stat_pkt_good, 1'b0);
                check_flag("stat_pkt_bad", stat_pkt_bad, 1'b0);
                check_flag("stat_err_bad_fcs", stat_err_bad_fcs, 1'b0);
                check_flag("stat_err_framing", stat_err_framing, 1'b0);
                check_flag("stat_err_oversize", stat_err_oversize, 1'b0);
                check_len("stat_pkt_len", stat_pkt_len, '0);
            end
            if (m_tvalid) begin
                if (frame_q.size() == 0) begin
                    report_failure("output word seen while no frame was in flight");
                end
                cur = frame_q[0];
                words_in_frame++;
                if (!cur.framing) begin
                    keep = exp_keep_q.pop_front();
                    for (int i = 0; i < xgmii_rx_pkg::LANES; i++) begin
                        mask[i*8 +: 8] = {8{keep[i]}};
                    end
                    check_keep("m_tkeep", m_tkeep, keep);
                    check_data("m_tdata", m_tdata & mask, exp_data_q.pop_front());
                    check_flag("m_tlast", m_tlast, 1'(words_in_frame == cur.words));
                end
                if (m_tlast) begin
                    if (cur.framing) begin
                        if (words_in_frame >= cur.words) begin
                            report_failure("frame with an error character was not cut short");
                        end
                        bad = 1'b1;
                    end else begin
                        bad = cur.bad_fcs || cur.oversize;
                        check_len("stat_pkt_len", stat_pkt_len, cur.len);
                        check_flag("stat_err_bad_fcs", stat_err_bad_fcs, cur.bad_fcs);
                        check_flag("stat_err_oversize", stat_err_oversize, cur.oversize);
                    end
                    check_flag("m_tuser", m_tuser, bad);
                    check_flag("stat_pkt_bad", stat_pkt_bad, bad);
                    check_flag("stat_pkt_good", stat_pkt_good, !bad);
                    check_flag("stat_err_framing", stat_err_framing, cur.framing);
                    frame_q.delete(0);
                    words_in_frame = 0;
                end
            end
        end
    end

    initial begin : watchdog
        int total_words;
        total_words = 0;
        for (int t = 64; t <= 71; t++) begin
            total_words += words_sent(t, GAP);
        end
        total_words += words_sent(BAD_FCS_LEN, GAP) + words_sent(OVERSIZE_LEN, GAP);
        total_words += words_sent(FRAMING_LEN, GAP) + words_sent(DISABLED_LEN, DISABLED_GAP);
        total_words += words_sent(B2B_FIRST_LEN, 0) + words_sent(B2B_SECOND_LEN, GAP);
        #(total_words * CLK_PERIOD * 2 + 100 * CLK_PERIOD);
        report_failure("timeout, the frames did not all come out in time");
    end

    initial begin : stimulus
        byte_q_t payload;
        void'($urandom(77));
        reset_crc = 1'b1;
        rx_enable = 1'b1;
        xgmii_rxd = IDLE_DATA;
        xgmii_rxc = '1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_crc = 1'b0;

        // one good frame per terminate lane
        for (int t = 64; t <= 71; t++) begin
            payload = random_payload(t - 4);
            send_frame(payload, 1'b0, -1, 1'b1, GAP);
        end

        payload = random_payload(BAD_FCS_LEN - 4);
        send_frame(payload, 1'b1, -1, 1'b1, GAP);
        payload = random_payload(OVERSIZE_LEN - 4);
        send_frame(payload, 1'b0, -1, 1'b1, GAP);
        // error character in the fifth data word
        payload = random_payload(FRAMING_LEN - 4);
        send_frame(payload, 1'b0, 4, 1'b1, GAP);

        wait_drained();
        rx_enable = 1'b0;
        payload = random_payload(DISABLED_LEN - 4);
        send_frame(payload, 1'b0, -1, 1'b0, DISABLED_GAP);
        rx_enable = 1'b1;

        // terminate in lane 5, next start word right behind
        payload = random_payload(B2B_FIRST_LEN - 4);
        send_frame(payload, 1'b0, -1, 1'b1, 0);
        payload = random_payload(B2B_SECOND_LEN - 4);
        send_frame(payload, 1'b0, -1, 1'b1, GAP);

        wait_drained();
        repeat (6) @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- xgmii_rx.f
logic/xgmii_rx_pkg.sv
logic/crc32_byte_step.sv
logic/xgmii_lane_align.sv
logic/fcs_checker.sv
logic/rx_frame_fsm.sv
logic/xgmii_rx_top.sv
verification/xgmii_rx_tb.sv
